// File: hdl/sb_msg_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "vref_cal_cfg.svh"

module sb_msg_queue (
	input  logic                  clk,
	input  logic                  i_reset,
	// responder push port, written first
	input  logic                  i_push_rx,
	input  vref_cal_pkg::sb_msg_e i_msg_rx,
	// initiator push port
	input  logic                  i_push_tx,
	input  vref_cal_pkg::sb_msg_e i_msg_tx,
	// sideband transmitter back-pressure
	input  logic                  i_busy,
	output vref_cal_pkg::sb_msg_e o_sideband_message,
	output logic                  o_valid
);

	import vref_cal_pkg::*;

	localparam int PTR_W = $clog2(`SB_QUEUE_DEPTH);

	sb_msg_e          mem [`SB_QUEUE_DEPTH];
	// extra msb tells full from empty
	logic [PTR_W:0]   wr_ptr;
	logic [PTR_W:0]   rd_ptr;
	logic [PTR_W-1:0] wr_idx_tx;
	logic             empty;
	logic             busy_q;
	logic             busy_fall;
	logic             issue;

	// tx lands behind rx when both push together
	assign wr_idx_tx = wr_ptr[PTR_W-1:0] + {{(PTR_W-1){1'b0}}, i_push_rx};
	assign empty     = (wr_ptr == rd_ptr);
	assign busy_fall = busy_q && !i_busy;

	// release of busy frees the sideband at once
	// otherwise idle for a cycle and no issue just before
	assign issue = !empty && (busy_fall || (!i_busy && !busy_q && !o_valid));

	always_ff @(posedge clk) begin
		if (i_push_rx) begin
			mem[wr_ptr[PTR_W-1:0]] <= i_msg_rx;
		end
		if (i_push_tx) begin
			mem[wr_idx_tx] <= i_msg_tx;
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			wr_ptr             <= '0;
			rd_ptr             <= '0;
			busy_q             <= 1'b0;
			o_valid            <= 1'b0;
			o_sideband_message <= SB_NONE;
		end else begin
			busy_q <= i_busy;
			wr_ptr <= wr_ptr + {{PTR_W{1'b0}}, i_push_rx} + {{PTR_W{1'b0}}, i_push_tx};
			// head goes out as a one cycle strobe
			o_valid <= issue;
			if (issue) begin
				o_sideband_message <= mem[rd_ptr[PTR_W-1:0]];
				rd_ptr             <= rd_ptr + 1'b1;
			end else begin
				o_sideband_message <= SB_NONE;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/vref_cal_cfg.svh
`ifndef VREF_CAL_CFG_SVH
`define VREF_CAL_CFG_SVH

// reference voltage control word width
`define VREF_W 4
// codes swept, 0 up to VREF_CODES-1
`define VREF_CODES 16
// code after reset or when nothing passes
`define VREF_DEFAULT 8
// sideband message width
`define SB_MSG_W 4
// lane result bits from the point test
`define LANES 16
// outgoing message queue entries
`define SB_QUEUE_DEPTH 4

`endif

// File: hdl/vref_cal_pkg.sv
`default_nettype none

`include "vref_cal_cfg.svh"

package vref_cal_pkg;

	// decoded sideband messages for vref calibration
	typedef enum logic [`SB_MSG_W-1:0] {
		SB_NONE       = 0,
		SB_START_REQ  = 1,
		SB_START_RESP = 2,
		SB_END_REQ    = 3,
		SB_END_RESP   = 4
	} sb_msg_e;

	// initiator FSM
	typedef enum logic [2:0] {
		TX_IDLE, TX_SEND_START, TX_WAIT_START, TX_SEND_END, TX_WAIT_END, TX_DONE
	} tx_state_e;

	// responder FSM
	typedef enum logic [2:0] {
		RX_IDLE, RX_SET_CODE, RX_TEST, RX_PICK, RX_WAIT_END, RX_DONE
	} rx_state_e;

endpackage

`default_nettype wire

// File: hdl/vref_cal_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "vref_cal_cfg.svh"

module vref_cal_rx (
	input  logic                  clk,
	input  logic                  i_reset,
	input  logic                  i_en,
	// partner messages from the sideband decoder
	input  vref_cal_pkg::sb_msg_e i_decoded_sideband_message,
	input  logic                  i_sideband_valid,
	// 0 mainband, 1 valid pattern
	input  logic                  i_mode,
	// point test handshake
	input  logic                  i_test_ack,
	input  logic [`LANES-1:0]     i_rx_lanes_result,
	// towards the message queue
	output vref_cal_pkg::sb_msg_e o_msg,
	output logic                  o_push,
	// test enables
	output logic                  o_pt_en,
	output logic                  o_eye_width_sweep_en,
	output logic                  o_done,
	// analog receiver control word
	output logic [`VREF_W-1:0]    o_reciever_ref_voltage
);

	import vref_cal_pkg::*;

	rx_state_e           state;
	logic [`VREF_W-1:0]  code;
	logic                end_seen;
	logic                start_req;
	logic                end_req;
	logic                code_pass;
	logic                last_code;
	// passing window tracking
	logic [`VREF_W-1:0]  cur_start;
	logic [`VREF_W-1:0]  best_start;
	logic [`VREF_W-1:0]  run_start;
	logic [`VREF_W:0]    cur_len;
	logic [`VREF_W:0]    best_len;
	logic [`VREF_W:0]    run_len;
	logic [`VREF_W:0]    centre;

	// requests are ours, responses belong to the initiator
	assign start_req = i_sideband_valid && (i_decoded_sideband_message == SB_START_REQ);
	assign end_req   = i_sideband_valid && (i_decoded_sideband_message == SB_END_REQ);

	// mainband needs every lane, valid pattern only lane 0
	assign code_pass = i_mode ? i_rx_lanes_result[0] : (&i_rx_lanes_result);
	assign last_code = (code == (`VREF_CODES - 1));

	// run extended by the current code if it passes
	assign run_start = (cur_len == '0) ? code : cur_start;
	assign run_len   = cur_len + 1'b1;

	// start plus half of (length - 1), rounded down
	assign centre = {1'b0, best_start} + ((best_len - 1'b1) >> 1);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state      <= RX_IDLE;
			code       <= `VREF_W'(`VREF_DEFAULT);
			end_seen   <= 1'b0;
			o_push     <= 1'b0;
			o_msg      <= SB_NONE;
			cur_start  <= '0;
			cur_len    <= '0;
			best_start <= '0;
			best_len   <= '0;
		end else begin
			// push is a single cycle strobe
			o_push <= 1'b0;
			if (!i_en) begin
				// final code stays until the next sweep
				state <= RX_IDLE;
			end else begin
				// end request may come early, remember it
				if (end_req && (state != RX_IDLE)) begin
					end_seen <= 1'b1;
				end
				case (state)
					RX_IDLE: begin
						if (start_req) begin
							code     <= '0;
							end_seen <= 1'b0;
							cur_len  <= '0;
							best_len <= '0;
							o_push   <= 1'b1;
							o_msg    <= SB_START_RESP;
							state    <= RX_SET_CODE;
						end
					end
					// code settles one cycle before the enable rises
					RX_SET_CODE: state <= RX_TEST;
					RX_TEST: begin
						if (i_test_ack) begin
							if (code_pass) begin
								cur_start <= run_start;
								cur_len   <= run_len;
								// strictly longer so ties keep the lower start
								if (run_len > best_len) begin
									best_start <= run_start;
									best_len   <= run_len;
								end
							end else begin
								cur_len <= '0;
							end
							if (last_code) begin
								state <= RX_PICK;
							end else begin
								code  <= code + 1'b1;
								state <= RX_SET_CODE;
							end
						end
					end
					RX_PICK: begin
						// no passing code falls back to default
						code  <= (best_len == '0) ? `VREF_W'(`VREF_DEFAULT) :
							centre[`VREF_W-1:0];
						state <= RX_WAIT_END;
					end
					RX_WAIT_END: begin
						if (end_seen || end_req) begin
							o_push <= 1'b1;
							o_msg  <= SB_END_RESP;
							state  <= RX_DONE;
						end
					end
					RX_DONE: state <= RX_DONE;
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	// enable held from state until the ack moves us on
	assign o_pt_en              = (state == RX_TEST) && !i_mode;
	assign o_eye_width_sweep_en = (state == RX_TEST) && i_mode;
	assign o_done                 = (state == RX_DONE);
	assign o_reciever_ref_voltage = code;

endmodule

`default_nettype wire

// File: hdl/vref_cal_tx.sv
`timescale 1ns/1ps
`default_nettype none

module vref_cal_tx (
	input  logic                  clk,
	input  logic                  i_reset,
	input  logic                  i_en,
	// partner messages from the sideband decoder
	input  vref_cal_pkg::sb_msg_e i_decoded_sideband_message,
	input  logic                  i_sideband_valid,
	// 0 mainband, 1 valid pattern
	input  logic                  i_mainband_or_valtrain_test,
	// towards the message queue
	output vref_cal_pkg::sb_msg_e o_msg,
	output logic                  o_push,
	output logic                  o_mode,
	output logic                  o_done
);

	import vref_cal_pkg::*;

	tx_state_e state;
	logic      start_resp_rcvd;
	logic      end_resp_rcvd;

	// only responses are ours, requests belong to the responder
	assign start_resp_rcvd = i_sideband_valid &&
		(i_decoded_sideband_message == SB_START_RESP);
	assign end_resp_rcvd = i_sideband_valid &&
		(i_decoded_sideband_message == SB_END_RESP);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state  <= TX_IDLE;
			o_mode <= 1'b0;
		end else if (!i_en) begin
			// enable low parks the FSM, mode is kept
			state <= TX_IDLE;
		end else begin
			case (state)
				TX_IDLE: begin
					// test mode frozen for the whole calibration
					o_mode <= i_mainband_or_valtrain_test;
					state  <= TX_SEND_START;
				end
				TX_SEND_START: state <= TX_WAIT_START;
				TX_WAIT_START: begin
					if (start_resp_rcvd) begin
						state <= TX_SEND_END;
					end
				end
				TX_SEND_END: state <= TX_WAIT_END;
				TX_WAIT_END: begin
					if (end_resp_rcvd) begin
						state <= TX_DONE;
					end
				end
				// hold done until enable drops
				TX_DONE: state <= TX_DONE;
				default: state <= TX_IDLE;
			endcase
		end
	end

	// one push per send state, each lasts a single cycle
	assign o_push = (state == TX_SEND_START) || (state == TX_SEND_END);
	assign o_msg  = (state == TX_SEND_END) ? SB_END_REQ : SB_START_REQ;
	assign o_done = (state == TX_DONE);

endmodule

`default_nettype wire

// File: hdl/vref_cal_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

`include "vref_cal_cfg.svh"

module vref_cal_wrapper (
	input  logic                 clk,
	input  logic                 i_reset,
	input  logic                 i_en,
	// sideband receive side
	input  logic [`SB_MSG_W-1:0] i_decoded_sideband_message,
	input  logic                 i_sideband_valid,
	// point test results and mode
	input  logic [`LANES-1:0]    i_rx_lanes_result,
	input  logic                 i_mainband_or_valtrain_test,
	input  logic                 i_busy,
	input  logic                 i_test_ack,
	// sideband transmit side
	output logic [`SB_MSG_W-1:0] o_sideband_message,
	output logic                 o_valid,
	// towards point test and eye sweep
	output logic                 o_mainband_or_valtrain_test,
	output logic                 o_test_ack,
	output logic                 o_pt_en,
	output logic                 o_eye_width_sweep_en,
	// analog receiver control word
	output logic [`VREF_W-1:0]   o_reciever_ref_voltage
);

	import vref_cal_pkg::*;

	sb_msg_e decoded_msg;
	sb_msg_e msg_tx;
	sb_msg_e msg_rx;
	sb_msg_e queue_msg;
	logic    push_tx;
	logic    push_rx;
	logic    done_tx;
	logic    done_rx;
	logic    mode;

	// raw sideband bits seen as message type
	assign decoded_msg                 = sb_msg_e'(i_decoded_sideband_message);
	assign o_sideband_message          = queue_msg;
	assign o_mainband_or_valtrain_test = mode;
	// calibration complete once both sides finish
	assign o_test_ack = done_tx && done_rx;

	vref_cal_tx tx_inst (
		.clk                         (clk),
		.i_reset                     (i_reset),
		.i_en                        (i_en),
		.i_decoded_sideband_message  (decoded_msg),
		.i_sideband_valid            (i_sideband_valid),
		.i_mainband_or_valtrain_test (i_mainband_or_valtrain_test),
		.o_msg                       (msg_tx),
		.o_push                      (push_tx),
		.o_mode                      (mode),
		.o_done                      (done_tx)
	);

	// responder follows the mode latched by the initiator
	vref_cal_rx rx_inst (
		.clk                    (clk),
		.i_reset                (i_reset),
		.i_en                   (i_en),
		.i_decoded_sideband_message (decoded_msg),
		.i_sideband_valid       (i_sideband_valid),
		.i_mode                 (mode),
		.i_test_ack             (i_test_ack),
		.i_rx_lanes_result      (i_rx_lanes_result),
		.o_msg                  (msg_rx),
		.o_push                 (push_rx),
		.o_pt_en                (o_pt_en),
		.o_eye_width_sweep_en   (o_eye_width_sweep_en),
		.o_done                 (done_rx),
		.o_reciever_ref_voltage (o_reciever_ref_voltage)
	);

	sb_msg_queue queue_inst (
		.clk                (clk),
		.i_reset            (i_reset),
		.i_push_rx          (push_rx),
		.i_msg_rx           (msg_rx),
		.i_push_tx          (push_tx),
		.i_msg_tx           (msg_tx),
		.i_busy             (i_busy),
		.o_sideband_message (queue_msg),
		.o_valid            (o_valid)
	);

endmodule

`default_nettype wire

// File: sim.f
+incdir+hdl
hdl/vref_cal_pkg.sv
hdl/vref_cal_tx.sv
hdl/vref_cal_rx.sv
hdl/sb_msg_queue.sv
hdl/vref_cal_wrapper.sv
tb/tb_vref_cal.sv

// File: tb/tb_vref_cal.sv
`timescale 1ns/1ps
`default_nettype none

`include "vref_cal_cfg.svh"

module tb_vref_cal;

	import vref_cal_pkg::*;

	localparam int CLK_PERIOD      = 20;
	localparam int RUNS            = 12;
	localparam int WATCHDOG_CYCLES = RUNS * `VREF_CODES * 30 + 2000;

	logic                 clk;
	logic                 i_reset = 1'b1;
	logic                 i_en = 1'b0;
	logic [`SB_MSG_W-1:0] i_decoded_sideband_message = '0;
	logic                 i_sideband_valid = 1'b0;
	logic [`LANES-1:0]    i_rx_lanes_result = '0;
	logic                 i_mainband_or_valtrain_test = 1'b0;
	logic                 i_busy = 1'b0;
	logic                 i_test_ack = 1'b0;
	logic [`SB_MSG_W-1:0] o_sideband_message;
	logic                 o_valid;
	logic                 o_mainband_or_valtrain_test;
	logic                 o_test_ack;
	logic                 o_pt_en;
	logic                 o_eye_width_sweep_en;
	logic [`VREF_W-1:0]   o_reciever_ref_voltage;

	// per run model state
	logic [`VREF_CODES-1:0] pass_map;
	logic                   run_mode = 1'b0;
	logic                   cur_pass = 1'b0;
	int                     exp_code = 0;
	int                     exp_centre = 0;
	int                     msg_cnt [0:4];
	logic                   start_req_sent = 1'b0;
	logic                   end_req_sent = 1'b0;
	logic                   end_resp_sent = 1'b0;
	// partner messages waiting to go out, with due cycle
	logic [`SB_MSG_W-1:0]   sb_msg_q [$];
	int                     sb_due_q [$];
	// previous edge samples
	logic                   rst_q = 1'b0;
	logic                   busy_q = 1'b0;
	logic                   valid_q = 1'b0;
	logic                   en_q = 1'b0;
	logic                   ack_q = 1'b0;
	logic                   en_now;
	logic                   next_ack;
	logic                   next_sb_valid;
	logic [`SB_MSG_W-1:0]   next_sb_msg;
	logic [`LANES-1:0]      next_lanes;
	int                     cyc = 0;
	int                     ack_wait = 0;
	int                     busy_left = 0;
	int                     ack_rises = 0;
	int                     pick;
	int                     run;
	int                     kind;
	int                     hole;
	int                     delay;
	int unsigned            rnd;

	vref_cal_wrapper dut0 (
		.clk                         (clk),
		.i_reset                     (i_reset),
		.i_en                        (i_en),
		.i_decoded_sideband_message  (i_decoded_sideband_message),
		.i_sideband_valid            (i_sideband_valid),
		.i_rx_lanes_result           (i_rx_lanes_result),
		.i_mainband_or_valtrain_test (i_mainband_or_valtrain_test),
		.i_busy                      (i_busy),
		.i_test_ack                  (i_test_ack),
		.o_sideband_message          (o_sideband_message),
		.o_valid                     (o_valid),
		.o_mainband_or_valtrain_test (o_mainband_or_valtrain_test),
		.o_test_ack                  (o_test_ack),
		.o_pt_en                     (o_pt_en),
		.o_eye_width_sweep_en        (o_eye_width_sweep_en),
		.o_reciever_ref_voltage      (o_reciever_ref_voltage)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	// queue a partner message some cycles from now
	task automatic schedule(input logic [`SB_MSG_W-1:0] m, input int wait_cycles);
		sb_msg_q.push_back(m);
		sb_due_q.push_back(cyc + wait_cycles);
	endtask

	// random passing window laid over the map
	function automatic logic [`VREF_CODES-1:0] add_window(input logic [`VREF_CODES-1:0] map);
		int s;
		int n;
		int i;
		s = $urandom_range(0, `VREF_CODES - 1);
		n = $urandom_range(1, `VREF_CODES);
		for (i = s; i < s + n && i < `VREF_CODES; i++) begin
			map[i] = 1'b1;
		end
		return map;
	endfunction

	// longest run of passes, lower start wins a tie
	function automatic int window_centre(input logic [`VREF_CODES-1:0] map);
		int s;
		int n;
		int best_s;
		int best_n;
		best_s = 0;
		best_n = 0;
		for (s = 0; s < `VREF_CODES; s++) begin
			if (map[s] && (s == 0 || !map[s-1])) begin
				n = 0;
				while (s + n < `VREF_CODES && map[s+n]) begin
					n++;
				end
				if (n > best_n) begin
					best_s = s;
					best_n = n;
				end
			end
		end
		return (best_n == 0) ? `VREF_DEFAULT : best_s + (best_n - 1) / 2;
	endfunction

	// lane word for one point test result
	function automatic logic [`LANES-1:0] lane_word(input logic pass, input logic mode);
		logic [`LANES-1:0] w;
		int                b;
		w = $urandom;
		b = $urandom_range(0, `LANES - 1);
		if (mode) begin
			w[0] = pass;
		end else begin
			w = '1;
			// mainband failure drops a single lane
			if (!pass) w[b] = 1'b0;
		end
		return w;
	endfunction

	// order rules for what the DUT sends, plus partner replies
	task automatic check_message(input logic [`SB_MSG_W-1:0] m);
		logic ok;
		case (m)
			SB_START_REQ:  ok = (msg_cnt[1] == 0);
			SB_START_RESP: ok = (msg_cnt[2] == 0) && start_req_sent;
			SB_END_REQ:    ok = (msg_cnt[3] == 0) && (msg_cnt[1] == 1);
			SB_END_RESP:   ok = (msg_cnt[4] == 0) && (msg_cnt[2] == 1) && end_req_sent;
			default:       ok = 1'b0;
		endcase
		assert (ok) else begin
			$display("[FAIL] o_sideband_message 0x%h out of order or repeated", m);
			abort_run();
		end
		msg_cnt[m] = msg_cnt[m] + 1;
		if (m == SB_START_REQ) schedule(SB_START_RESP, $urandom_range(1, 12));
		if (m == SB_END_REQ) schedule(SB_END_RESP, $urandom_range(1, 12));
	endtask

	// monitor, partner, busy and point test models on one edge
	always @(posedge clk) begin
		if (i_reset && rst_q) begin
			assert (o_valid == 1'b0) else begin
				$display("o_valid went high during reset");
				abort_run();
			end
		end
		en_now = o_pt_en | o_eye_width_sweep_en;
		if (!i_reset) begin
			if (o_valid) begin
				assert (!busy_q && !valid_q) else begin
					$display("o_valid issued while busy or right after an issue");
					abort_run();
				end
				check_message(o_sideband_message);
			end
			assert (!(o_pt_en && o_eye_width_sweep_en)) else begin
				$display("both test enables high together");
				abort_run();
			end
			if (en_now && !en_q) begin
				assert (o_reciever_ref_voltage == exp_code && exp_code < `VREF_CODES) else begin
					$display("[FAIL] o_reciever_ref_voltage got 0x%h expected 0x%h",
						o_reciever_ref_voltage, exp_code);
					abort_run();
				end
				assert (o_mainband_or_valtrain_test == run_mode) else begin
					$display("[FAIL] o_mainband_or_valtrain_test got 0x%h expected 0x%h",
						o_mainband_or_valtrain_test, run_mode);
					abort_run();
				end
				assert (run_mode ? o_eye_width_sweep_en : o_pt_en) else begin
					$display("wrong test enable raised for mode %0d", run_mode);
					abort_run();
				end
				cur_pass = pass_map[exp_code];
				exp_code = exp_code + 1;
				ack_wait = $urandom_range(1, 8);
			end
			if (o_test_ack && !ack_q) begin
				assert (end_resp_sent && exp_code == `VREF_CODES) else begin
					$display("o_test_ack rose before the sweep and end handshake finished");
					abort_run();
				end
				assert (o_reciever_ref_voltage == exp_centre) else begin
					$display("[FAIL] o_reciever_ref_voltage got 0x%h expected 0x%h",
						o_reciever_ref_voltage, exp_centre);
					abort_run();
				end
				ack_rises = ack_rises + 1;
			end
		end
		rst_q   = i_reset;
		busy_q  = i_busy;
		valid_q = o_valid;
		en_q    = en_now;
		ack_q   = o_test_ack;
		// ack pulse after the drawn delay
		next_ack   = 1'b0;
		next_lanes = '0;
		if (ack_wait != 0) begin
			ack_wait = ack_wait - 1;
			if (ack_wait == 0) begin
				next_ack   = 1'b1;
				next_lanes = lane_word(cur_pass, run_mode);
			end
		end
		// busy follows each issue for 0 to 5 cycles
		if (o_valid === 1'b1) begin
			busy_left = $urandom_range(0, 5);
		end else if (busy_left != 0) begin
			busy_left = busy_left - 1;
		end
		// oldest due partner message goes first
		next_sb_valid = 1'b0;
		next_sb_msg   = SB_NONE;
		pick          = -1;
		for (int i = 0; i < sb_msg_q.size(); i++) begin
			if (pick < 0 && sb_due_q[i] <= cyc) pick = i;
		end
		if (pick >= 0) begin
			next_sb_valid = 1'b1;
			next_sb_msg   = sb_msg_q[pick];
			if (next_sb_msg == SB_START_REQ) start_req_sent = 1'b1;
			if (next_sb_msg == SB_END_REQ) end_req_sent = 1'b1;
			if (next_sb_msg == SB_END_RESP) end_resp_sent = 1'b1;
			sb_msg_q.delete(pick);
			sb_due_q.delete(pick);
		end
		cyc = cyc + 1;
		#2;
		i_test_ack                 = next_ack;
		i_rx_lanes_result          = next_lanes;
		i_sideband_valid           = next_sb_valid;
		i_decoded_sideband_message = next_sb_msg;
		i_busy                     = (busy_left != 0);
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout, calibration runs did not finish in time");
		abort_run();
	end

	initial begin
		rnd = $urandom(32'hc90f);
		repeat (10) @(posedge clk);
		#2;
		i_reset = 1'b0;
		assert (o_valid == 1'b0 && o_pt_en == 1'b0 && o_eye_width_sweep_en == 1'b0 &&
			o_test_ack == 1'b0 && o_sideband_message == SB_NONE &&
			o_reciever_ref_voltage == `VREF_DEFAULT && o_mainband_or_valtrain_test == 1'b0)
		else begin
			$display("outputs not at their reset values after reset");
			abort_run();
		end
		for (run = 0; run < RUNS; run++) begin
			// kind 0 all fail, 1 one window, 2 two windows, 3 window with a hole
			kind     = $urandom_range(0, 3);
			hole     = $urandom_range(0, `VREF_CODES - 1);
			pass_map = '0;
			if (kind != 0) pass_map = add_window(pass_map);
			if (kind == 2) pass_map = add_window(pass_map);
			if (kind == 3) pass_map[hole] = 1'b0;
			run_mode   = $urandom_range(0, 1);
			exp_centre = window_centre(pass_map);
			exp_code   = 0;
			for (int k = 0; k < 5; k++) begin
				msg_cnt[k] = 0;
			end
			start_req_sent = 1'b0;
			end_req_sent   = 1'b0;
			end_resp_sent  = 1'b0;
			i_mainband_or_valtrain_test = run_mode;
			i_en = 1'b1;
			// partner start, then its end request some time later
			delay = $urandom_range(1, 10);
			schedule(SB_START_REQ, delay);
			schedule(SB_END_REQ, delay + $urandom_range(1, 300));
			wait (ack_rises == run + 1);
			// own end response may still sit in the queue
			wait (msg_cnt[4] == 1);
			assert (msg_cnt[1] == 1 && msg_cnt[2] == 1 && msg_cnt[3] == 1) else begin
				$display("a sideband message is missing at the end of run %0d", run);
				abort_run();
			end
			@(posedge clk);
			#2;
			i_en = 1'b0;
			repeat (2) @(posedge clk);
			assert (o_test_ack == 1'b0) else begin
				$display("o_test_ack still high after enable dropped in run %0d", run);
				abort_run();
			end
			// final code held while idle
			assert (o_reciever_ref_voltage == exp_centre) else begin
				$display("[FAIL] o_reciever_ref_voltage got 0x%h expected 0x%h",
					o_reciever_ref_voltage, exp_centre);
				abort_run();
			end
			repeat ($urandom_range(2, 6)) @(posedge clk);
			#2;
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
